/* source/tile_mem_pkg.sv */
`default_nettype none

package tile_mem_pkg;

   //////////////////////////////
   // data path widths
   //////////////////////////////

   // one data word
   typedef logic [31:0] word_t;

   // byte enables, one per byte of word_t
   typedef logic [$bits(word_t)/8-1:0] mask_t;

   // core byte address, bit 31 marks a remote request
   // the network side reuses this width for word addresses
   typedef logic [31:0] byte_addr_t;

   //////////////////////////////
   // default sizes
   //////////////////////////////

   // words per bank
   localparam int default_bank_words = 256;

   // number of local banks, power of two
   localparam int default_num_banks = 2;

   // receive FIFO depth
   localparam int default_fifo_els = 4;

   // outgoing request credits
   localparam int default_max_credits = 8;

endpackage

`default_nettype wire

/* source/core_request_router.sv */
`timescale 1ns/10ps
`default_nettype none

module core_request_router
  #(parameter int max_credits_p    = 8
    , parameter int mem_addr_width_p = 9
    )
   (input  wire                        clk_i
    , input  wire                      reset_i

    // core request, held until core_yumi_o
    , input  wire                      core_v_i
    , input  wire                      core_we_i
    , input  wire                      core_reserve_i
    , input  tile_mem_pkg::byte_addr_t core_addr_i
    , input  tile_mem_pkg::word_t      core_wdata_i
    , input  tile_mem_pkg::mask_t      core_mask_i
    , output logic                     core_yumi_o

    // local memory side
    , output logic                        loc_v_o
    , output logic                        loc_we_o
    , output logic                        loc_reserve_o
    , output logic [mem_addr_width_p-1:0] loc_addr_o
    , output tile_mem_pkg::word_t         loc_wdata_o
    , output tile_mem_pkg::mask_t         loc_mask_o
    , input  wire                         loc_yumi_i

    // network side
    , output logic                      out_v_o
    , output logic                      out_we_o
    , output tile_mem_pkg::byte_addr_t  out_addr_o
    , output tile_mem_pkg::word_t       out_data_o
    , output tile_mem_pkg::mask_t       out_mask_o
    , input  wire                       out_ready_i
    , input  wire                       credit_return_i
    , output logic                      outstanding_stores_o
    );

   localparam int credit_width_lp = $clog2(max_credits_p + 1);

   logic                       remote;
   logic                       launch;
   logic [credit_width_lp-1:0] credits_r;

   // bit 31 picks the network
   assign remote = core_addr_i[31];

   // local path, byte bits dropped from the address
   assign loc_v_o       = core_v_i & ~remote;
   assign loc_we_o      = core_we_i;
   assign loc_reserve_o = core_reserve_i;
   assign loc_addr_o    = core_addr_i[2 +: mem_addr_width_p];
   assign loc_wdata_o   = core_wdata_i;
   assign loc_mask_o    = core_mask_i;

   // remote path leaves untouched, only when a credit is left
   assign out_v_o    = core_v_i & remote & (credits_r != '0);
   assign out_we_o   = core_we_i;
   assign out_addr_o = core_addr_i;
   assign out_data_o = core_wdata_i;
   assign out_mask_o = core_mask_i;

   assign launch = out_v_o & out_ready_i;

   // request is consumed by whichever side took it
   assign core_yumi_o = loc_yumi_i | launch;

   //////////////////////////////
   // credit counter
   //////////////////////////////
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         credits_r <= credit_width_lp'(max_credits_p);
      end
      else if (launch & ~credit_return_i)
      begin
         credits_r <= credits_r - 1'b1;
      end
      else if (credit_return_i & ~launch)
      begin
         credits_r <= credits_r + 1'b1;
      end
   end

   // anything below the full count is still in flight
   assign outstanding_stores_o = (credits_r != credit_width_lp'(max_credits_p));

endmodule

`default_nettype wire

/* source/remote_store_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module remote_store_fifo
  #(parameter int els_p = 4)
   (input  wire                        clk_i
    , input  wire                      reset_i

    // enqueue side from the network
    , input  wire                      in_v_i
    , input  tile_mem_pkg::byte_addr_t in_addr_i
    , input  tile_mem_pkg::word_t      in_data_i
    , input  tile_mem_pkg::mask_t      in_mask_i
    , output logic                     in_ready_o

    // head of the queue popped by yumi_i
    , output logic                     v_o
    , output tile_mem_pkg::byte_addr_t addr_o
    , output tile_mem_pkg::word_t      data_o
    , output tile_mem_pkg::mask_t      mask_o
    , input  wire                      yumi_i
    );

   localparam int ptr_width_lp   = (els_p > 1) ? $clog2(els_p) : 1;
   localparam int count_width_lp = $clog2(els_p + 1);
   localparam int entry_width_lp = $bits(tile_mem_pkg::byte_addr_t)
                                 + $bits(tile_mem_pkg::word_t)
                                 + $bits(tile_mem_pkg::mask_t);

   // address, data and mask of one store kept side by side
   logic [entry_width_lp-1:0] mem_r [els_p];

   logic [ptr_width_lp-1:0]   wr_ptr_r;
   logic [ptr_width_lp-1:0]   rd_ptr_r;
   logic [count_width_lp-1:0] count_r;
   logic                      enq;

   assign in_ready_o = (count_r != count_width_lp'(els_p));
   assign v_o        = (count_r != '0);
   assign enq        = in_v_i & in_ready_o;

   assign {addr_o, data_o, mask_o} = mem_r[rd_ptr_r];

   // entry storage for queued stores
   always_ff @(posedge clk_i)
   begin
      if (enq)
      begin
         mem_r[wr_ptr_r] <= {in_addr_i, in_data_i, in_mask_i};
      end
   end

   //////////////////////////////
   // pointers and occupancy
   //////////////////////////////
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         // pointers wrap at els_p so any depth works
         if (enq)
         begin
            wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(els_p - 1)) ? '0 : wr_ptr_r + 1'b1;
         end
         if (yumi_i)
         begin
            rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(els_p - 1)) ? '0 : rd_ptr_r + 1'b1;
         end
         if (enq & ~yumi_i)
         begin
            count_r <= count_r + 1'b1;
         end
         else if (yumi_i & ~enq)
         begin
            count_r <= count_r - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* source/mem_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_bank
  #(parameter int words_p = 256)
   (input  wire                             clk_i
    , input  wire                           v_i
    , input  wire                           we_i
    , input  wire [$clog2(words_p)-1:0]     addr_i
    , input  tile_mem_pkg::word_t           data_i
    , input  tile_mem_pkg::mask_t           mask_i
    , output tile_mem_pkg::word_t           data_o
    );

   tile_mem_pkg::word_t mem_r [words_p];
   tile_mem_pkg::word_t data_r;

   always_ff @(posedge clk_i)
   begin
      if (v_i & we_i)
      begin
         // only the enabled bytes change
         for (int i = 0; i < $bits(tile_mem_pkg::mask_t); i++)
         begin
            if (mask_i[i])
            begin
               mem_r[addr_i][8*i +: 8] <= data_i[8*i +: 8];
            end
         end
      end
      else if (v_i)
      begin
         // registered read, held until the next read
         data_r <= mem_r[addr_i];
      end
   end

   assign data_o = data_r;

endmodule

`default_nettype wire

/* source/banked_mem_xbar.sv */
`timescale 1ns/10ps
`default_nettype none

module banked_mem_xbar
  #(parameter int num_banks_p = 2
    , parameter int bank_size_p = 256
    , localparam int addr_width_lp = $clog2(bank_size_p) + $clog2(num_banks_p)
    )
   (input  wire                        clk_i
    , input  wire                      reset_i

    // core port, always granted
    , input  wire                      core_v_i
    , input  wire                      core_we_i
    , input  wire                      core_reserve_i
    , input  wire [addr_width_lp-1:0]  core_addr_i
    , input  tile_mem_pkg::word_t      core_data_i
    , input  tile_mem_pkg::mask_t      core_mask_i
    , output logic                     core_yumi_o

    // fifo port, remote stores only
    , input  wire                      fifo_v_i
    , input  tile_mem_pkg::byte_addr_t fifo_addr_i
    , input  tile_mem_pkg::word_t      fifo_data_i
    , input  tile_mem_pkg::mask_t      fifo_mask_i
    , output logic                     fifo_yumi_o

    // core read return and load-reserved state
    , output logic                     rv_o
    , output tile_mem_pkg::word_t      rdata_o
    , output logic                     reservation_o
    );

   localparam int bank_bits_lp = $clog2(num_banks_p);
   localparam int row_bits_lp  = $clog2(bank_size_p);

   logic [addr_width_lp-1:0] fifo_addr;
   logic [bank_bits_lp-1:0]  core_bank, fifo_bank;
   logic [row_bits_lp-1:0]   core_row, fifo_row;

   logic                     rv_r;
   logic [bank_bits_lp-1:0]  bank_sel_r;
   logic                     reservation_r;
   logic [addr_width_lp-1:0] reserve_addr_r;

   tile_mem_pkg::word_t bank_rdata [num_banks_p];

   // network address arrives with byte bits already gone
   assign fifo_addr = fifo_addr_i[addr_width_lp-1:0];

   //////////////////////////////
   // swizzle, low bits pick bank
   //////////////////////////////
   assign core_bank = core_addr_i[bank_bits_lp-1:0];
   assign core_row  = core_addr_i[addr_width_lp-1:bank_bits_lp];
   assign fifo_bank = fifo_addr[bank_bits_lp-1:0];
   assign fifo_row  = fifo_addr[addr_width_lp-1:bank_bits_lp];

   // core wins every conflict, fifo waits for a free bank
   assign core_yumi_o = core_v_i;
   assign fifo_yumi_o = fifo_v_i & ~(core_v_i & (core_bank == fifo_bank));

   for (genvar b = 0; b < num_banks_p; b++)
   begin : bank
      logic core_hit;
      logic fifo_hit;

      assign core_hit = core_v_i & (core_bank == bank_bits_lp'(b));
      assign fifo_hit = fifo_yumi_o & (fifo_bank == bank_bits_lp'(b));

      // fifo side is always a write
      mem_bank #(.words_p(bank_size_p)) u_bank
        (.clk_i  (clk_i)
         ,.v_i    (core_hit | fifo_hit)
         ,.we_i   (core_hit ? core_we_i   : 1'b1)
         ,.addr_i (core_hit ? core_row    : fifo_row)
         ,.data_i (core_hit ? core_data_i : fifo_data_i)
         ,.mask_i (core_hit ? core_mask_i : fifo_mask_i)
         ,.data_o (bank_rdata[b])
         );
   end

   //////////////////////////////
   // read return
   //////////////////////////////
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         rv_r <= 1'b0;
      end
      else
      begin
         rv_r <= core_v_i & ~core_we_i;
      end
   end

   // remembers which bank answers next cycle
   always_ff @(posedge clk_i)
   begin
      bank_sel_r <= core_bank;
   end

   assign rv_o    = rv_r;
   assign rdata_o = bank_rdata[bank_sel_r];

   //////////////////////////////
   // load reserved
   //////////////////////////////
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         reservation_r <= 1'b0;
      end
      else if (core_v_i & core_reserve_i & ~core_we_i)
      begin
         reservation_r <= 1'b1;
      end
      else if (fifo_yumi_o & (fifo_addr == reserve_addr_r))
      begin
         // a remote store to the watched word breaks it
         reservation_r <= 1'b0;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (core_v_i & core_reserve_i & ~core_we_i)
      begin
         reserve_addr_r <= core_addr_i;
      end
   end

   assign reservation_o = reservation_r;

endmodule

`default_nettype wire

/* source/tile_mem_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tile_mem_top
  #(parameter int bank_size_p     = tile_mem_pkg::default_bank_words
    , parameter int num_banks_p   = tile_mem_pkg::default_num_banks
    , parameter int fifo_els_p    = tile_mem_pkg::default_fifo_els
    , parameter int max_credits_p = tile_mem_pkg::default_max_credits
    )
   (input  wire                        clk_i
    , input  wire                      reset_i

    // core port
    , input  wire                      core_v_i
    , input  wire                      core_we_i
    , input  wire                      core_reserve_i
    , input  tile_mem_pkg::byte_addr_t core_addr_i
    , input  tile_mem_pkg::word_t      core_wdata_i
    , input  tile_mem_pkg::mask_t      core_mask_i
    , output logic                     core_yumi_o
    , output logic                     core_rv_o
    , output tile_mem_pkg::word_t      core_rdata_o
    , output logic                     core_reservation_o

    // outgoing remote requests
    , output logic                     out_v_o
    , output logic                     out_we_o
    , output tile_mem_pkg::byte_addr_t out_addr_o
    , output tile_mem_pkg::word_t      out_data_o
    , output tile_mem_pkg::mask_t      out_mask_o
    , input  wire                      out_ready_i
    , input  wire                      credit_return_i
    , output logic                     outstanding_stores_o

    // incoming remote stores, word addressed
    , input  wire                      in_v_i
    , input  tile_mem_pkg::byte_addr_t in_addr_i
    , input  tile_mem_pkg::word_t      in_data_i
    , input  tile_mem_pkg::mask_t      in_mask_i
    , output logic                     in_ready_o
    );

   localparam int mem_addr_width_lp = $clog2(bank_size_p) + $clog2(num_banks_p);

   // router to crossbar
   logic                         loc_v, loc_we, loc_reserve, loc_yumi;
   logic [mem_addr_width_lp-1:0] loc_addr;
   tile_mem_pkg::word_t          loc_wdata;
   tile_mem_pkg::mask_t          loc_mask;

   // fifo to crossbar
   logic                         fifo_v, fifo_yumi;
   tile_mem_pkg::byte_addr_t     fifo_addr;
   tile_mem_pkg::word_t          fifo_data;
   tile_mem_pkg::mask_t          fifo_mask;

   core_request_router
     #(.max_credits_p    (max_credits_p)
       ,.mem_addr_width_p (mem_addr_width_lp)
       ) u_router
     (.clk_i, .reset_i
      ,.core_v_i, .core_we_i, .core_reserve_i, .core_addr_i
      ,.core_wdata_i, .core_mask_i, .core_yumi_o
      ,.loc_v_o       (loc_v)
      ,.loc_we_o      (loc_we)
      ,.loc_reserve_o (loc_reserve)
      ,.loc_addr_o    (loc_addr)
      ,.loc_wdata_o   (loc_wdata)
      ,.loc_mask_o    (loc_mask)
      ,.loc_yumi_i    (loc_yumi)
      ,.out_v_o, .out_we_o, .out_addr_o, .out_data_o, .out_mask_o
      ,.out_ready_i, .credit_return_i, .outstanding_stores_o
      );

   remote_store_fifo #(.els_p(fifo_els_p)) u_fifo
     (.clk_i, .reset_i
      ,.in_v_i, .in_addr_i, .in_data_i, .in_mask_i, .in_ready_o
      ,.v_o    (fifo_v)
      ,.addr_o (fifo_addr)
      ,.data_o (fifo_data)
      ,.mask_o (fifo_mask)
      ,.yumi_i (fifo_yumi)
      );

   banked_mem_xbar
     #(.num_banks_p  (num_banks_p)
       ,.bank_size_p (bank_size_p)
       ) u_xbar
     (.clk_i, .reset_i
      ,.core_v_i       (loc_v)
      ,.core_we_i      (loc_we)
      ,.core_reserve_i (loc_reserve)
      ,.core_addr_i    (loc_addr)
      ,.core_data_i    (loc_wdata)
      ,.core_mask_i    (loc_mask)
      ,.core_yumi_o    (loc_yumi)
      ,.fifo_v_i       (fifo_v)
      ,.fifo_addr_i    (fifo_addr)
      ,.fifo_data_i    (fifo_data)
      ,.fifo_mask_i    (fifo_mask)
      ,.fifo_yumi_o    (fifo_yumi)
      ,.rv_o           (core_rv_o)
      ,.rdata_o        (core_rdata_o)
      ,.reservation_o  (core_reservation_o)
      );

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

// free running testbench clock
module tb_clock_gen
  #(parameter int period_ns_p = 40)
   (output logic clk_o
    );

   initial
   begin
      clk_o = 1'b0;
      forever #(period_ns_p/2) clk_o = ~clk_o;
   end

endmodule

`default_nettype wire

/* tests/tile_mem_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module tile_mem_checker
  #(parameter int max_credits_p = 8)
   (input  wire                        clk_i
    , input  wire                      reset_i
    , input  wire                      core_v_i
    , input  wire                      core_we_i
    , input  tile_mem_pkg::byte_addr_t core_addr_i
    , input  wire                      core_yumi_o
    , input  wire                      core_rv_o
    , input  wire                      out_v_o
    , input  wire                      out_ready_i
    , input  wire                      credit_return_i
    , input  wire                      in_v_i
    , input  wire                      in_ready_o
    );

   int   credits;
   int   fail_count = 0;
   logic local_rd;

   // accepted local read on this edge
   assign local_rd = core_v_i & core_yumi_o & ~core_we_i & ~core_addr_i[31];

   // shadow credit count from the port activity
   always @(posedge clk_i)
   begin
      if (reset_i)
      begin
         credits <= max_credits_p;
      end
      else
      begin
         credits <= credits - int'(out_v_o & out_ready_i) + int'(credit_return_i);
      end
   end

   assert property (@(posedge clk_i) disable iff (reset_i) out_v_o |-> credits > 0)
      else
      begin
         $error("out_v_o raised with no credit left");
         fail_count++;
      end

   assert property (@(posedge clk_i) disable iff (reset_i) local_rd |=> core_rv_o)
      else
      begin
         $error("core_rv_o missing after an accepted local read");
         fail_count++;
      end

   assert property (@(posedge clk_i) disable iff (reset_i) core_rv_o |-> $past(local_rd))
      else
      begin
         $error("core_rv_o raised without a local read");
         fail_count++;
      end

   assert property (@(posedge clk_i) disable iff (reset_i) in_v_i |-> in_ready_o)
      else
      begin
         $error("in_v_i driven while the receive FIFO is full");
         fail_count++;
      end

endmodule

bind tile_mem_top tile_mem_checker #(.max_credits_p(max_credits_p)) u_checker
  (.clk_i           (clk_i)
   ,.reset_i         (reset_i)
   ,.core_v_i        (core_v_i)
   ,.core_we_i       (core_we_i)
   ,.core_addr_i     (core_addr_i)
   ,.core_yumi_o     (core_yumi_o)
   ,.core_rv_o       (core_rv_o)
   ,.out_v_o         (out_v_o)
   ,.out_ready_i     (out_ready_i)
   ,.credit_return_i (credit_return_i)
   ,.in_v_i          (in_v_i)
   ,.in_ready_o      (in_ready_o)
   );

`default_nettype wire

/* tests/tile_mem_monitor.sv */
`timescale 1ns/10ps
`default_nettype none

module tile_mem_monitor
  #(parameter int num_banks_p = 2
    , parameter int bank_size_p = 256
    , parameter int fifo_els_p = 4
    , parameter int max_credits_p = 8
    )
   (input  wire                        clk_i
    , input  wire                      reset_i
    , input  wire                      core_v_i
    , input  wire                      core_we_i
    , input  wire                      core_reserve_i
    , input  tile_mem_pkg::byte_addr_t core_addr_i
    , input  tile_mem_pkg::word_t      core_wdata_i
    , input  tile_mem_pkg::mask_t      core_mask_i
    , input  wire                      core_yumi_o
    , input  wire                      core_rv_o
    , input  tile_mem_pkg::word_t      core_rdata_o
    , input  wire                      core_reservation_o
    , input  wire                      out_v_o
    , input  wire                      out_we_o
    , input  tile_mem_pkg::byte_addr_t out_addr_o
    , input  tile_mem_pkg::word_t      out_data_o
    , input  tile_mem_pkg::mask_t      out_mask_o
    , input  wire                      out_ready_i
    , input  wire                      credit_return_i
    , input  wire                      outstanding_stores_o
    , input  wire                      in_v_i
    , input  tile_mem_pkg::byte_addr_t in_addr_i
    , input  tile_mem_pkg::word_t      in_data_i
    , input  tile_mem_pkg::mask_t      in_mask_i
    , input  wire                      in_ready_o
    );

   localparam int aw_lp = $clog2(num_banks_p * bank_size_p);
   localparam int bb_lp = $clog2(num_banks_p);

   string test_name = "reset";
   int    errors = 0;
   int    pending_stores = 0;

   // reference memory and model state
   tile_mem_pkg::word_t      ref_mem [num_banks_p * bank_size_p];
   tile_mem_pkg::byte_addr_t st_addr_q [$];
   tile_mem_pkg::word_t      st_data_q [$];
   tile_mem_pkg::mask_t      st_mask_q [$];
   int                       credits;
   logic                     res_v;
   logic [aw_lp-1:0]         res_addr;
   logic                     rd_pend;
   tile_mem_pkg::word_t      rd_exp;

   // byte merge of a store into an old word
   function automatic tile_mem_pkg::word_t merge_word(tile_mem_pkg::word_t old_w,
                                                      tile_mem_pkg::word_t new_w,
                                                      tile_mem_pkg::mask_t m);
      tile_mem_pkg::word_t w;
      w = old_w;
      for (int i = 0; i < $bits(tile_mem_pkg::mask_t); i++)
      begin
         if (m[i])
         begin
            w[8*i +: 8] = new_w[8*i +: 8];
         end
      end
      return w;
   endfunction

   // credit count after one edge
   function automatic int next_credits(int cur, logic launch, logic ret);
      return cur - int'(launch) + int'(ret);
   endfunction

   task automatic report_value(string what, logic [31:0] exp, logic [31:0] act);
      errors++;
      $display("ERROR %s: %s expected %h actual %h", test_name, what, exp, act);
   endtask

   //////////////////////////////
   // compare, then advance model
   //////////////////////////////
   always @(posedge clk_i)
   begin : compare
      logic                     loc;
      logic                     remote;
      logic                     launch;
      logic                     pop;
      logic                     room;
      logic [aw_lp-1:0]         word;
      logic [aw_lp-1:0]         head_word;
      tile_mem_pkg::byte_addr_t head_full;

      if (reset_i)
      begin
         st_addr_q.delete();
         st_data_q.delete();
         st_mask_q.delete();
         credits = max_credits_p;
         res_v   = 1'b0;
         rd_pend = 1'b0;
      end
      else
      begin
         word   = core_addr_i[2 +: aw_lp];
         loc    = core_v_i & ~core_addr_i[31];
         remote = core_v_i & core_addr_i[31];
         launch = remote & (credits > 0) & out_ready_i;
         room   = (st_addr_q.size() < fifo_els_p);

         if (core_rv_o !== rd_pend)
            report_value("core_rv_o", 32'(rd_pend), 32'(core_rv_o));
         else if (rd_pend && core_rdata_o !== rd_exp)
            report_value("read data", rd_exp, core_rdata_o);
         if (core_reservation_o !== res_v)
            report_value("core_reservation_o", 32'(res_v), 32'(core_reservation_o));
         if (outstanding_stores_o !== (credits < max_credits_p))
            report_value("outstanding_stores_o", 32'(credits < max_credits_p),
                         32'(outstanding_stores_o));
         if (in_ready_o !== room)
            report_value("in_ready_o", 32'(room), 32'(in_ready_o));
         if (out_v_o !== (remote & (credits > 0)))
            report_value("out_v_o", 32'(remote & (credits > 0)), 32'(out_v_o));
         if (core_yumi_o !== (loc | launch))
            report_value("core_yumi_o", 32'(loc | launch), 32'(core_yumi_o));
         if (launch && out_addr_o !== core_addr_i)
            report_value("out_addr_o", core_addr_i, out_addr_o);
         if (launch && out_data_o !== core_wdata_i)
            report_value("out_data_o", core_wdata_i, out_data_o);
         if (launch && (out_mask_o !== core_mask_i || out_we_o !== core_we_i))
            report_value("out_mask_o and out_we_o", {core_we_i, core_mask_i},
                         {out_we_o, out_mask_o});

         // head drains unless the core holds its bank
         pop = 1'b0;
         head_word = '0;
         if (st_addr_q.size() > 0)
         begin
            head_full = st_addr_q[0];
            head_word = head_full[aw_lp-1:0];
            pop = !(loc && word[bb_lp-1:0] == head_word[bb_lp-1:0]);
         end

         rd_pend = loc & ~core_we_i;
         if (loc && !core_we_i)
            rd_exp = ref_mem[word];
         if (loc && core_we_i)
            ref_mem[word] = merge_word(ref_mem[word], core_wdata_i, core_mask_i);
         if (pop)
            ref_mem[head_word] = merge_word(ref_mem[head_word], st_data_q[0], st_mask_q[0]);

         // set wins over a clear on the same edge
         if (loc && core_reserve_i && !core_we_i)
         begin
            res_v    = 1'b1;
            res_addr = word;
         end
         else if (pop && head_word == res_addr)
         begin
            res_v = 1'b0;
         end

         if (pop)
         begin
            void'(st_addr_q.pop_front());
            void'(st_data_q.pop_front());
            void'(st_mask_q.pop_front());
         end
         if (in_v_i && room)
         begin
            st_addr_q.push_back(in_addr_i);
            st_data_q.push_back(in_data_i);
            st_mask_q.push_back(in_mask_i);
         end
         credits = next_credits(credits, launch, credit_return_i);
      end
      pending_stores = st_addr_q.size();
   end

endmodule

`default_nettype wire

/* tests/tile_mem_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module tile_mem_tb;

   localparam int n_words_lp   = 16;
   localparam int n_starve_lp  = 12;
   localparam int n_credits_lp = tile_mem_pkg::default_max_credits;
   // every request, store and credit pulse issued below
   localparam int total_ops_lp = 3*n_words_lp + n_starve_lp + 4 + 3
                               + 2*(n_credits_lp + 1) + 3 + 2;
   localparam int max_cycles_lp = 8*total_ops_lp + 200;

   logic clk_i;
   logic reset_i;
   logic core_v_i, core_we_i, core_reserve_i;
   tile_mem_pkg::byte_addr_t core_addr_i;
   tile_mem_pkg::word_t      core_wdata_i;
   tile_mem_pkg::mask_t      core_mask_i;
   logic core_yumi_o, core_rv_o, core_reservation_o;
   tile_mem_pkg::word_t      core_rdata_o;
   logic out_v_o, out_we_o, out_ready_i, credit_return_i, outstanding_stores_o;
   tile_mem_pkg::byte_addr_t out_addr_o;
   tile_mem_pkg::word_t      out_data_o;
   tile_mem_pkg::mask_t      out_mask_o;
   logic in_v_i, in_ready_o;
   tile_mem_pkg::byte_addr_t in_addr_i;
   tile_mem_pkg::word_t      in_data_i;
   tile_mem_pkg::mask_t      in_mask_i;

   int seed = 32'ha53b_7437;
   int tb_errors = 0;
   int cycles = 0;

   tb_clock_gen #(.period_ns_p(40)) u_clk (.clk_o(clk_i));

   tile_mem_top u_dut (.*);

   tile_mem_monitor u_mon (.*);

   //////////////////////////////
   // stimulus helpers
   //////////////////////////////
   function automatic tile_mem_pkg::byte_addr_t local_addr(int word);
      return tile_mem_pkg::byte_addr_t'(word) << 2;
   endfunction

   // request stays up after acceptance so the next one follows without a gap
   task automatic core_req(logic we, logic res, tile_mem_pkg::byte_addr_t a,
                           tile_mem_pkg::word_t d, tile_mem_pkg::mask_t m);
      @(negedge clk_i);
      core_v_i       = 1'b1;
      core_we_i      = we;
      core_reserve_i = res;
      core_addr_i    = a;
      core_wdata_i   = d;
      core_mask_i    = m;
      do @(posedge clk_i); while (!core_yumi_o);
   endtask

   task automatic core_idle();
      @(negedge clk_i);
      core_v_i       = 1'b0;
      core_reserve_i = 1'b0;
   endtask

   task automatic push_store(int word, tile_mem_pkg::word_t d, tile_mem_pkg::mask_t m);
      @(negedge clk_i);
      while (!in_ready_o)
      begin
         in_v_i = 1'b0;
         @(negedge clk_i);
      end
      in_v_i    = 1'b1;
      in_addr_i = tile_mem_pkg::byte_addr_t'(word);
      in_data_i = d;
      in_mask_i = m;
      @(posedge clk_i);
   endtask

   task automatic store_idle();
      @(negedge clk_i);
      in_v_i = 1'b0;
   endtask

   task automatic credit_pulse();
      @(negedge clk_i);
      credit_return_i = 1'b1;
      @(negedge clk_i);
      credit_return_i = 1'b0;
   endtask

   task automatic wait_drained();
      @(negedge clk_i);
      while (u_mon.pending_stores != 0)
         @(negedge clk_i);
   endtask

   task automatic expect_level(string what, logic exp, logic act);
      if (act !== exp)
      begin
         tb_errors++;
         $display("ERROR %s: %s expected %0b actual %0b", u_mon.test_name, what, exp, act);
      end
   endtask

   // run limit
   always @(posedge clk_i)
   begin
      cycles++;
      if (cycles > max_cycles_lp)
      begin
         $display("timeout: run did not finish within %0d cycles", max_cycles_lp);
         $display("** FAIL **");
         $finish;
      end
   end

   initial
   begin
      reset_i = 1'b1;
      core_v_i = 1'b0;
      core_we_i = 1'b0;
      core_reserve_i = 1'b0;
      core_addr_i = '0;
      core_wdata_i = '0;
      core_mask_i = '0;
      out_ready_i = 1'b0;
      credit_return_i = 1'b0;
      in_v_i = 1'b0;
      in_addr_i = '0;
      in_data_i = '0;
      in_mask_i = '0;
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;

      u_mon.test_name = "reset";
      expect_level("out_v_o", 1'b0, out_v_o);
      expect_level("core_rv_o", 1'b0, core_rv_o);
      expect_level("core_reservation_o", 1'b0, core_reservation_o);
      expect_level("in_ready_o", 1'b1, in_ready_o);

      // full writes first, then masked merges on top
      u_mon.test_name = "local";
      for (int i = 0; i < n_words_lp; i++)
         core_req(1'b1, 1'b0, local_addr(16 + i), $random(seed), 4'hf);
      for (int i = 0; i < n_words_lp; i++)
         core_req(1'b1, 1'b0, local_addr(16 + i), $random(seed),
                  tile_mem_pkg::mask_t'($random(seed)));
      for (int i = 0; i < n_words_lp; i++)
         core_req(1'b0, 1'b0, local_addr(16 + i), '0, '0);
      core_idle();

      // core keeps bank 0 busy so the FIFO fills
      u_mon.test_name = "remote_store";
      fork
         begin
            for (int i = 0; i < n_starve_lp; i++)
               core_req(1'b0, 1'b0, local_addr(22 + 2*(i % 4)), '0, '0);
            core_idle();
         end
         begin
            push_store(16, $random(seed), tile_mem_pkg::mask_t'($random(seed)));
            push_store(18, $random(seed), 4'hf);
            push_store(16, $random(seed), 4'hf);
            push_store(20, $random(seed), 4'h5);
            store_idle();
            expect_level("in_ready_o while full", 1'b0, in_ready_o);
         end
      join
      wait_drained();
      core_req(1'b0, 1'b0, local_addr(16), '0, '0);
      core_req(1'b0, 1'b0, local_addr(18), '0, '0);
      core_req(1'b0, 1'b0, local_addr(20), '0, '0);
      core_idle();

      // first launch held back by out_ready_i
      u_mon.test_name = "credits";
      fork
         core_req(1'b1, 1'b0, 32'h8000_0000 | $random(seed), $random(seed), 4'hf);
         begin
            repeat (3) @(negedge clk_i);
            out_ready_i = 1'b1;
         end
      join
      for (int i = 1; i < n_credits_lp; i++)
         core_req(1'b1, 1'b0, 32'h8000_0000 | $random(seed), $random(seed), 4'h3);
      fork
         core_req(1'b0, 1'b0, 32'h8000_0000 | $random(seed), '0, '0);
         begin
            repeat (3) @(negedge clk_i);
            expect_level("out_v_o with no credit", 1'b0, out_v_o);
            credit_pulse();
         end
      join
      core_idle();
      for (int i = 0; i < n_credits_lp; i++)
         credit_pulse();
      expect_level("outstanding_stores_o", 1'b0, outstanding_stores_o);

      u_mon.test_name = "reservation";
      core_req(1'b1, 1'b0, local_addr(40), $random(seed), 4'hf);
      core_req(1'b1, 1'b0, local_addr(42), $random(seed), 4'hf);
      core_req(1'b0, 1'b1, local_addr(40), '0, '0);
      core_idle();
      expect_level("core_reservation_o after reserve", 1'b1, core_reservation_o);
      push_store(42, $random(seed), 4'hf);
      store_idle();
      wait_drained();
      expect_level("core_reservation_o other word", 1'b1, core_reservation_o);
      push_store(40, $random(seed), 4'hf);
      store_idle();
      wait_drained();
      expect_level("core_reservation_o same word", 1'b0, core_reservation_o);

      repeat (2) @(negedge clk_i);
      $display("errors: %0d monitor, %0d testbench, %0d assertion",
               u_mon.errors, tb_errors, u_dut.u_checker.fail_count);
      if (u_mon.errors == 0 && tb_errors == 0 && u_dut.u_checker.fail_count == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
source/tile_mem_pkg.sv
source/core_request_router.sv
source/remote_store_fifo.sv
source/mem_bank.sv
source/banked_mem_xbar.sv
source/tile_mem_top.sv
tests/tb_clock_gen.sv
tests/tile_mem_checker.sv
tests/tile_mem_monitor.sv
tests/tile_mem_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the tile memory testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tile_mem_tb \
   -f flist.f -o tile_mem_sim > build.log 2>&1 \
   && ./obj_dir/tile_mem_sim > sim.log 2>&1
grep -qxF '** PASS **' sim.log 2>/dev/null && echo "simulation passed" \
   || { echo "simulation failed, see build.log and sim.log"; exit 1; }
